// ==== verilog/cdi_bus_pkg.sv ====
package cdi_bus_pkg;

    // Bus word types
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [23:1] addr_t;

    // Response of one target: read word and its ack level
    typedef struct packed {
        word_t data;
        logic  ack;
    } resp_t;

    typedef struct packed {
        logic slave;
        logic cdic;
        logic mpeg;
        logic nvram;
        logic video;
        logic rom;
    } target_sel_t;

    // Owner of the shared level 4 interrupt line
    typedef enum logic [1:0] {
        IRQ_IDLE = 2'd0,
        IRQ_CDIC = 2'd1,
        IRQ_MPEG = 2'd2
    } irq_owner_t;

    // Auto-boot ROM window
    localparam logic [23:0] ROM_BASE  = 24'hF00000;
    localparam logic [23:0] ROM_LAST  = 24'hF00068;
    localparam int          ROM_DEPTH = 64;
    localparam int          ROM_WORDS = 53;

    // Bus error regions, upper bounds exclusive
    localparam logic [23:0] ERR1_LO = 24'h080000;
    localparam logic [23:0] ERR1_HI = 24'h200000;
    localparam logic [23:0] ERR2_LO = 24'h500000;
    localparam logic [23:0] ERR2_HI = 24'hD00000;
    localparam logic [23:0] ERR3_LO = 24'hF10000;

    // Target pages and patterns
    localparam logic [7:0]  CDIC_PAGE       = 8'h30;
    localparam logic [7:0]  SLAVE_PAGE      = 8'h31;
    localparam logic [7:0]  NVRAM_PAGE      = 8'h32;
    localparam logic [5:0]  MPEG_PAT        = 6'b111000;
    localparam logic [5:0]  DVC_ROM_PAT     = 6'b111001;
    localparam logic [4:0]  MPEG_RAM_PAT    = 5'b11101;
    localparam logic [3:0]  DVC_RAM_NIB     = 4'hD;
    localparam logic [23:0] VIDEO_LOW_LAST  = 24'h27FFFF;
    localparam logic [23:0] VIDEO_HIGH_BASE = 24'h400000;

endpackage

// ==== verilog/cpu_bus_if.sv ====
`timescale 1ns/1ps

interface cpu_bus_if
    import cdi_bus_pkg::*;
();

    addr_t addr;
    logic  as;
    logic  uds;
    logic  lds;

    // Driven from the CPU side pins
    modport host (
        output addr,
        output as,
        output uds,
        output lds
    );

    // Decoder and targets only watch the bus
    modport listener (
        input addr,
        input as,
        input uds,
        input lds
    );

endinterface

// ==== verilog/addr_decoder.sv ====
`timescale 1ns/1ps

module addr_decoder
    import cdi_bus_pkg::*;
(
    cpu_bus_if.listener bus,
    input  logic        config_disable_vmpeg,
    input  logic        mpeg_ram_enabled,
    input  logic        rom_active,
    output target_sel_t sel,
    output logic        bus_err
);

    logic [23:0] addr_byte;
    logic        video_cs;
    logic        dvc_ram_cs;
    logic        dvc_rom_cs;
    logic        rom_window;
    logic        err_area1;
    logic        err_area2;
    logic        err_area3;
    logic        err_area4;
    logic        err_area5;

    assign addr_byte = {bus.addr, 1'b0};

    // Main video RAM and registers, low half of the map only
    assign video_cs = ((addr_byte <= VIDEO_LOW_LAST) || (addr_byte >= VIDEO_HIGH_BASE))
                      && !bus.addr[23];

    // DVC RAM and ROM are answered by the video controller too
    assign dvc_ram_cs = (addr_byte[23:20] == DVC_RAM_NIB)
                        || (addr_byte[23:19] == MPEG_RAM_PAT);
    assign dvc_rom_cs = (addr_byte[23:18] == DVC_ROM_PAT);

    assign rom_window = (addr_byte >= ROM_BASE) && (addr_byte <= ROM_LAST);

    always_comb begin
        sel.slave = bus.as && (addr_byte[23:16] == SLAVE_PAGE);
        sel.cdic  = bus.as && (addr_byte[23:16] == CDIC_PAGE);
        sel.nvram = bus.as && (addr_byte[23:16] == NVRAM_PAGE);
        sel.mpeg  = bus.as && (addr_byte[23:18] == MPEG_PAT) && !config_disable_vmpeg;
        sel.video = bus.as && (video_cs || dvc_ram_cs || dvc_rom_cs);
        sel.rom   = bus.as && rom_window && rom_active;
    end

    assign err_area1 = (addr_byte >= ERR1_LO) && (addr_byte < ERR1_HI);
    assign err_area2 = (addr_byte >= ERR2_LO) && (addr_byte < ERR2_HI);
    assign err_area3 = (addr_byte >= ERR3_LO);
    // ROM space faults when auto boot is off
    assign err_area4 = (addr_byte >= ROM_BASE) && !rom_active;
    // MPEG RAM stays closed until the decoder opens it
    assign err_area5 = (addr_byte[23:19] == MPEG_RAM_PAT) && !mpeg_ram_enabled;

    assign bus_err = (err_area1 || err_area2 || err_area3 || err_area4 || err_area5)
                     && bus.as && (bus.uds || bus.lds);

endmodule

// ==== verilog/boot_rom.sv ====
`timescale 1ns/1ps

module boot_rom
    import cdi_bus_pkg::*;
(
    input  logic        clk30,
    input  logic        reset,
    input  logic        slave_reset,
    cpu_bus_if.listener bus,
    input  logic        rom_sel,
    input  logic        cd_img_mounted,
    input  logic        config_auto_play,
    input  logic        audio_cd_in_tray,
    output logic        rom_active,
    output resp_t       resp
);

    word_t rom [ROM_DEPTH];
    logic  last_reset_by_slave;

    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = '0;
        end
        $readmemh("boot_rom.mem", rom, 0, ROM_WORDS - 1);
    end

    // Word lookup is registered, so the first selected cycle has no ack
    always_ff @(posedge clk30) begin
        resp.data <= rom[bus.addr[6:1]];
    end

    always_ff @(posedge clk30) begin
        if (reset) begin
            resp.ack <= 1'b0;
        end else begin
            resp.ack <= rom_sel && !resp.ack;
        end
    end

    // Remembers a reset requested by the slave, e.g. quitting to the shell
    always_ff @(posedge clk30) begin
        if (reset) begin
            last_reset_by_slave <= 1'b0;
        end else if (slave_reset) begin
            last_reset_by_slave <= 1'b1;
        end
    end

    assign rom_active = cd_img_mounted && config_auto_play && !audio_cd_in_tray
                        && !last_reset_by_slave;

endmodule

// ==== verilog/slave_port.sv ====
`timescale 1ns/1ps

module slave_port
    import cdi_bus_pkg::*;
(
    input  logic  clk30,
    input  logic  reset,
    input  logic  slave_sel,
    input  logic  slave_dtack,
    input  byte_t slave_porta,
    output resp_t resp,
    output logic  slave_irq
);

    logic sel_q;
    logic dtack_q;

    always_ff @(posedge clk30) begin
        if (reset) begin
            sel_q   <= 1'b0;
            dtack_q <= 1'b0;
        end else begin
            sel_q   <= slave_sel;
            dtack_q <= slave_dtack;
        end
    end

    // One cycle pulses on the rising edges
    assign slave_irq = slave_sel && !sel_q;
    assign resp.ack  = slave_dtack && !dtack_q;

    // Port A is byte wide, mirrored on both lanes
    assign resp.data = {slave_porta, slave_porta};

endmodule

// ==== verilog/irq4_arbiter.sv ====
`timescale 1ns/1ps

module irq4_arbiter
    import cdi_bus_pkg::*;
(
    input  logic clk30,
    input  logic reset,
    input  logic cdic_intreq,
    input  logic mpeg_intreq,
    input  logic iack4,
    output logic in4,
    output logic cdic_intack,
    output logic mpeg_intack
);

    irq_owner_t owner;

    // Owner holds the line until it drops its own request
    always_ff @(posedge clk30) begin
        if (reset) begin
            owner <= IRQ_IDLE;
        end else begin
            case (owner)
                IRQ_CDIC: begin
                    if (!cdic_intreq) owner <= IRQ_IDLE;
                end
                IRQ_MPEG: begin
                    if (!mpeg_intreq) owner <= IRQ_IDLE;
                end
                default: begin
                    // MPEG wins a tie
                    if (mpeg_intreq) owner <= IRQ_MPEG;
                    else if (cdic_intreq) owner <= IRQ_CDIC;
                end
            endcase
        end
    end

    assign in4 = ((owner == IRQ_CDIC) && cdic_intreq) || ((owner == IRQ_MPEG) && mpeg_intreq);

    assign cdic_intack = iack4 && (owner == IRQ_CDIC);
    assign mpeg_intack = iack4 && (owner == IRQ_MPEG);

endmodule

// ==== verilog/bus_response_mux.sv ====
`timescale 1ns/1ps

module bus_response_mux
    import cdi_bus_pkg::*;
(
    input  target_sel_t sel,
    input  resp_t       video_resp,
    input  resp_t       cdic_resp,
    input  resp_t       mpeg_resp,
    input  resp_t       nvram_resp,
    input  resp_t       slave_resp,
    input  resp_t       rom_resp,
    input  logic        cdic_intack,
    input  logic        mpeg_intack,
    output word_t       data_in,
    output logic        bus_ack
);

    resp_t chosen;

    always_comb begin
        // Unmapped reads finish immediately with zero
        chosen.data = '0;
        chosen.ack  = 1'b1;

        if (sel.slave) begin
            chosen = slave_resp;
        end else if (sel.cdic) begin
            chosen = cdic_resp;
        end else if (sel.mpeg) begin
            chosen = mpeg_resp;
        end else if (sel.nvram) begin
            chosen = nvram_resp;
        end else if (sel.video) begin
            chosen = video_resp;
        end else if (sel.rom) begin
            chosen = rom_resp;
        end

        // Interrupt vector fetch goes to the current level 4 owner
        if (cdic_intack) begin
            chosen.data = cdic_resp.data;
            chosen.ack  = 1'b1;
        end

        if (mpeg_intack) begin
            chosen.data = mpeg_resp.data;
            chosen.ack  = 1'b1;
        end
    end

    assign data_in = chosen.data;
    assign bus_ack = chosen.ack;

endmodule

// ==== verilog/cdi_bus_glue.sv ====
`timescale 1ns/1ps

module cdi_bus_glue
    import cdi_bus_pkg::*;
(
    input  logic  clk30,
    input  logic  reset,
    input  logic  slave_reset,
    input  addr_t addr,
    input  logic  as,
    input  logic  uds,
    input  logic  lds,
    input  word_t video_dout,
    input  word_t cdic_dout,
    input  word_t mpeg_dout,
    input  logic  video_ack,
    input  logic  cdic_ack,
    input  logic  mpeg_ack,
    input  byte_t nvram_dout,
    input  logic  nvram_ack,
    input  byte_t slave_porta,
    input  logic  slave_dtack,
    input  logic  cdic_intreq,
    input  logic  mpeg_intreq,
    input  logic  iack4,
    input  logic  cd_img_mounted,
    input  logic  config_auto_play,
    input  logic  audio_cd_in_tray,
    input  logic  config_disable_vmpeg,
    input  logic  mpeg_ram_enabled,
    output word_t data_in,
    output logic  bus_ack,
    output logic  bus_err,
    output logic  video_cs,
    output logic  cdic_cs,
    output logic  mpeg_cs,
    output logic  nvram_cs,
    output logic  slave_irq,
    output logic  in4,
    output logic  cdic_intack,
    output logic  mpeg_intack
);

    cpu_bus_if bus ();

    target_sel_t sel;
    logic        rom_active;
    resp_t       video_resp;
    resp_t       cdic_resp;
    resp_t       mpeg_resp;
    resp_t       nvram_resp;
    resp_t       slave_resp;
    resp_t       rom_resp;

    assign bus.addr = addr;
    assign bus.as   = as;
    assign bus.uds  = uds;
    assign bus.lds  = lds;

    // External targets answer through plain ports
    assign video_resp = '{data: video_dout, ack: video_ack};
    assign cdic_resp  = '{data: cdic_dout, ack: cdic_ack};
    assign mpeg_resp  = '{data: mpeg_dout, ack: mpeg_ack};
    // NVRAM is byte wide
    assign nvram_resp = '{data: {nvram_dout, nvram_dout}, ack: nvram_ack};

    assign video_cs = sel.video;
    assign cdic_cs  = sel.cdic;
    assign mpeg_cs  = sel.mpeg;
    assign nvram_cs = sel.nvram;

    addr_decoder addr_decoder_inst (
        .bus                  (bus),
        .config_disable_vmpeg (config_disable_vmpeg),
        .mpeg_ram_enabled     (mpeg_ram_enabled),
        .rom_active           (rom_active),
        .sel                  (sel),
        .bus_err              (bus_err)
    );

    boot_rom boot_rom_inst (
        .clk30            (clk30),
        .reset            (reset),
        .slave_reset      (slave_reset),
        .bus              (bus),
        .rom_sel          (sel.rom),
        .cd_img_mounted   (cd_img_mounted),
        .config_auto_play (config_auto_play),
        .audio_cd_in_tray (audio_cd_in_tray),
        .rom_active       (rom_active),
        .resp             (rom_resp)
    );

    slave_port slave_port_inst (
        .clk30       (clk30),
        .reset       (reset),
        .slave_sel   (sel.slave),
        .slave_dtack (slave_dtack),
        .slave_porta (slave_porta),
        .resp        (slave_resp),
        .slave_irq   (slave_irq)
    );

    irq4_arbiter irq4_arbiter_inst (
        .clk30       (clk30),
        .reset       (reset),
        .cdic_intreq (cdic_intreq),
        .mpeg_intreq (mpeg_intreq),
        .iack4       (iack4),
        .in4         (in4),
        .cdic_intack (cdic_intack),
        .mpeg_intack (mpeg_intack)
    );

    bus_response_mux bus_response_mux_inst (
        .sel         (sel),
        .video_resp  (video_resp),
        .cdic_resp   (cdic_resp),
        .mpeg_resp   (mpeg_resp),
        .nvram_resp  (nvram_resp),
        .slave_resp  (slave_resp),
        .rom_resp    (rom_resp),
        .cdic_intack (cdic_intack),
        .mpeg_intack (mpeg_intack),
        .data_in     (data_in),
        .bus_ack     (bus_ack)
    );

endmodule

// ==== dv/cdi_bus_glue_asserts.sv ====
`timescale 1ns/1ps

module cdi_bus_glue_asserts
    import cdi_bus_pkg::*;
(
    input logic       clk30,
    input logic       reset,
    input logic       slave_irq,
    input logic       cdic_intreq,
    input logic       mpeg_intreq,
    input logic       in4,
    input logic       cdic_intack,
    input logic       mpeg_intack,
    input irq_owner_t owner
);

    // Select pulse to the slave is a single cycle
    slave_irq_single_cycle: assert property (
        @(posedge clk30) disable iff (reset)
        slave_irq |=> !slave_irq
    ) else $error("slave_irq stayed high for two cycles");

    // Vector fetch goes to one owner, which was asking a cycle earlier
    cdic_intack_owned: assert property (
        @(posedge clk30) disable iff (reset)
        cdic_intack |-> !mpeg_intack && $past(cdic_intreq)
    ) else $error("cdic_intack without a CDIC request or together with mpeg_intack");

    mpeg_intack_owned: assert property (
        @(posedge clk30) disable iff (reset)
        mpeg_intack |-> !cdic_intack && $past(mpeg_intreq)
    ) else $error("mpeg_intack without an MPEG request or together with cdic_intack");

    // With no request the owner falls back to idle and in4 drops
    in4_quiet_when_idle: assert property (
        @(posedge clk30) disable iff (reset)
        !cdic_intreq && !mpeg_intreq |=> (owner == IRQ_IDLE) && !in4
    ) else $error("in4 or an owner remained after both requests dropped");

endmodule

// ==== dv/cdi_bus_glue_tb.sv ====
`timescale 1ns/1ps

module cdi_bus_glue_tb
    import cdi_bus_pkg::*;
();

    // One decode check
    // Select bits in order slave cdic mpeg nvram video rom
    typedef struct packed {
        logic [23:0] byte_addr;
        logic [2:0]  strobes;
        logic        disable_vmpeg;
        logic        ram_enabled;
        target_sel_t exp_sel;
        logic        exp_err;
    } decode_row_t;

    logic  clk30;
    logic  reset;
    logic  slave_reset;
    addr_t addr;
    logic  as;
    logic  uds;
    logic  lds;
    word_t video_dout;
    word_t cdic_dout;
    word_t mpeg_dout;
    logic  video_ack;
    logic  cdic_ack;
    logic  mpeg_ack;
    byte_t nvram_dout;
    logic  nvram_ack;
    byte_t slave_porta;
    logic  slave_dtack;
    logic  cdic_intreq;
    logic  mpeg_intreq;
    logic  iack4;
    logic  cd_img_mounted;
    logic  config_auto_play;
    logic  audio_cd_in_tray;
    logic  config_disable_vmpeg;
    logic  mpeg_ram_enabled;
    word_t data_in;
    logic  bus_ack;
    logic  bus_err;
    logic  video_cs;
    logic  cdic_cs;
    logic  mpeg_cs;
    logic  nvram_cs;
    logic  slave_irq;
    logic  in4;
    logic  cdic_intack;
    logic  mpeg_intack;

    decode_row_t decode_table [$];

    cdi_bus_glue cdi_bus_glue_inst (.*);

    bind cdi_bus_glue cdi_bus_glue_asserts cdi_bus_glue_asserts_inst (
        .clk30       (clk30),
        .reset       (reset),
        .slave_irq   (slave_irq),
        .cdic_intreq (cdic_intreq),
        .mpeg_intreq (mpeg_intreq),
        .in4         (in4),
        .cdic_intack (cdic_intack),
        .mpeg_intack (mpeg_intack),
        .owner       (irq4_arbiter_inst.owner)
    );

    initial begin
        clk30 = 1'b0;
        forever #50 clk30 = ~clk30;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_sel(input string name, input target_sel_t got,
                               input target_sel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Called right after a drive edge and samples on falling edges
    task automatic wait_for_ack(input int max_cycles, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk30);
        while (bus_ack !== 1'b1) begin
            if (cycles >= max_cycles) begin
                abort_run($sformatf("Timed out waiting for the bus ack of %s", what));
            end else begin
                @(negedge clk30);
                cycles++;
            end
        end
    endtask

    task automatic wait_for_in4(input int max_cycles, input string what);
        int cycles;
        cycles = 0;
        while (in4 !== 1'b1) begin
            if (cycles >= max_cycles) begin
                abort_run($sformatf("Timed out waiting for in4 from %s", what));
            end else begin
                @(negedge clk30);
                cycles++;
            end
        end
    endtask

    task automatic add_row(input logic [23:0] byte_addr, input logic [2:0] strobes,
                           input logic [1:0] cfg, input target_sel_t exp_sel,
                           input logic exp_err);
        decode_row_t row;
        row.byte_addr     = byte_addr;
        row.strobes       = strobes;
        row.disable_vmpeg = cfg[1];
        row.ram_enabled   = cfg[0];
        row.exp_sel       = exp_sel;
        row.exp_err       = exp_err;
        decode_table.push_back(row);
    endtask

    // Strobes are {as, uds, lds}
    // Config bits are {disable_vmpeg, mpeg_ram_enabled}
    task automatic build_decode_table();
        add_row(24'h000100, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'h07FFFE, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'h080000, 3'b111, 2'b01, 6'b000010, 1'b1);
        add_row(24'h100000, 3'b111, 2'b01, 6'b000010, 1'b1);
        add_row(24'h100000, 3'b100, 2'b01, 6'b000010, 1'b0);
        add_row(24'h250000, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'h2A0000, 3'b111, 2'b01, 6'b000000, 1'b0);
        add_row(24'h300010, 3'b111, 2'b01, 6'b010000, 1'b0);
        add_row(24'h310020, 3'b111, 2'b01, 6'b100000, 1'b0);
        add_row(24'h320040, 3'b101, 2'b01, 6'b000100, 1'b0);
        add_row(24'h600000, 3'b111, 2'b01, 6'b000010, 1'b1);
        add_row(24'h900000, 3'b111, 2'b01, 6'b000000, 1'b1);
        add_row(24'h900000, 3'b000, 2'b01, 6'b000000, 1'b0);
        add_row(24'hD00000, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'hE00000, 3'b111, 2'b01, 6'b001000, 1'b0);
        add_row(24'hE00000, 3'b111, 2'b11, 6'b000000, 1'b0);
        add_row(24'hE40000, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'hE80000, 3'b111, 2'b01, 6'b000010, 1'b0);
        add_row(24'hE80000, 3'b111, 2'b00, 6'b000010, 1'b1);
        add_row(24'hE80000, 3'b100, 2'b00, 6'b000010, 1'b0);
        add_row(24'hF00000, 3'b111, 2'b01, 6'b000000, 1'b1);
        add_row(24'hF00000, 3'b110, 2'b01, 6'b000000, 1'b1);
        add_row(24'hF00000, 3'b100, 2'b01, 6'b000000, 1'b0);
        add_row(24'hF20000, 3'b111, 2'b01, 6'b000000, 1'b1);
        add_row(24'hF20000, 3'b100, 2'b01, 6'b000000, 1'b0);
        add_row(24'h300010, 3'b011, 2'b01, 6'b000000, 1'b0);
    endtask

    task automatic apply_decode_row(input decode_row_t row);
        word_t      vid;
        word_t      cd;
        word_t      mp;
        byte_t      nv;
        byte_t      pa;
        logic [3:0] acks;
        word_t      exp_data;
        logic       exp_ack;
        vid  = word_t'($urandom);
        cd   = word_t'($urandom);
        mp   = word_t'($urandom);
        nv   = byte_t'($urandom);
        pa   = byte_t'($urandom);
        acks = 4'($urandom);
        @(posedge clk30);
        addr                 <= row.byte_addr[23:1];
        {as, uds, lds}       <= row.strobes;
        config_disable_vmpeg <= row.disable_vmpeg;
        mpeg_ram_enabled     <= row.ram_enabled;
        video_dout           <= vid;
        cdic_dout            <= cd;
        mpeg_dout            <= mp;
        nvram_dout           <= nv;
        slave_porta          <= pa;
        {video_ack, cdic_ack, mpeg_ack, nvram_ack} <= acks;
        // Unselected reads end at once with zero
        exp_data = 16'h0000;
        exp_ack  = 1'b1;
        if (row.exp_sel.slave) begin
            // dtack stays low here, so no ack edge
            exp_data = {pa, pa};
            exp_ack  = 1'b0;
        end else if (row.exp_sel.cdic) begin
            exp_data = cd;
            exp_ack  = acks[2];
        end else if (row.exp_sel.mpeg) begin
            exp_data = mp;
            exp_ack  = acks[1];
        end else if (row.exp_sel.nvram) begin
            exp_data = {nv, nv};
            exp_ack  = acks[0];
        end else if (row.exp_sel.video) begin
            exp_data = vid;
            exp_ack  = acks[3];
        end
        @(negedge clk30);
        compare_sel("sel", cdi_bus_glue_inst.sel, row.exp_sel);
        compare_bit("video_cs", video_cs, row.exp_sel.video);
        compare_bit("cdic_cs", cdic_cs, row.exp_sel.cdic);
        compare_bit("mpeg_cs", mpeg_cs, row.exp_sel.mpeg);
        compare_bit("nvram_cs", nvram_cs, row.exp_sel.nvram);
        compare_bit("slave_irq", slave_irq, row.exp_sel.slave);
        compare_bit("bus_err", bus_err, row.exp_err);
        compare_word("data_in", data_in, exp_data);
        compare_bit("bus_ack", bus_ack, exp_ack);
    endtask

    task automatic read_rom_word(input int index);
        @(posedge clk30);
        addr <= ROM_BASE[23:1] + 23'(index);
        as   <= 1'b1;
        uds  <= 1'b1;
        lds  <= 1'b1;
        wait_for_ack(4, "the boot ROM");
        compare_word("data_in", data_in, 16'h5000 + 16'(index));
        compare_bit("bus_err", bus_err, 1'b0);
        @(posedge clk30);
        as  <= 1'b0;
        uds <= 1'b0;
        lds <= 1'b0;
    endtask

    task automatic run_boot_rom_test();
        @(posedge clk30);
        cd_img_mounted       <= 1'b1;
        config_auto_play     <= 1'b1;
        audio_cd_in_tray     <= 1'b0;
        config_disable_vmpeg <= 1'b0;
        mpeg_ram_enabled     <= 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) begin
            read_rom_word(i);
        end
        // Reset from the slave turns auto boot off
        @(posedge clk30);
        slave_reset <= 1'b1;
        @(posedge clk30);
        slave_reset <= 1'b0;
        @(posedge clk30);
        addr <= ROM_BASE[23:1];
        as   <= 1'b1;
        uds  <= 1'b1;
        lds  <= 1'b1;
        @(negedge clk30);
        compare_bit("bus_err", bus_err, 1'b1);
        compare_bit("sel.rom", cdi_bus_glue_inst.sel.rom, 1'b0);
        @(posedge clk30);
        as    <= 1'b0;
        uds   <= 1'b0;
        lds   <= 1'b0;
        reset <= 1'b1;
        repeat (10) @(posedge clk30);
        reset <= 1'b0;
        read_rom_word(0);
    endtask

    task automatic run_slave_port_test();
        byte_t port_byte;
        port_byte = byte_t'($urandom);
        @(posedge clk30);
        addr        <= {SLAVE_PAGE, 15'h0000};
        as          <= 1'b1;
        uds         <= 1'b0;
        lds         <= 1'b1;
        slave_porta <= port_byte;
        slave_dtack <= 1'b0;
        @(negedge clk30);
        compare_bit("slave_irq", slave_irq, 1'b1);
        compare_bit("bus_ack", bus_ack, 1'b0);
        @(negedge clk30);
        compare_bit("slave_irq", slave_irq, 1'b0);
        @(posedge clk30);
        slave_dtack <= 1'b1;
        @(negedge clk30);
        compare_bit("bus_ack", bus_ack, 1'b1);
        compare_word("data_in", data_in, {port_byte, port_byte});
        @(negedge clk30);
        compare_bit("bus_ack", bus_ack, 1'b0);
        compare_bit("slave_irq", slave_irq, 1'b0);
        @(posedge clk30);
        as          <= 1'b0;
        uds         <= 1'b0;
        lds         <= 1'b0;
        slave_dtack <= 1'b0;
    endtask

    task automatic run_irq4_test();
        word_t cdic_word;
        word_t mpeg_word;
        word_t video_word;
        cdic_word  = word_t'($urandom);
        mpeg_word  = word_t'($urandom);
        video_word = word_t'($urandom);
        @(posedge clk30);
        // Video space with its ack held low, so only the override ends the fetch
        addr        <= 23'h000080;
        video_dout  <= video_word;
        video_ack   <= 1'b0;
        cdic_dout   <= cdic_word;
        mpeg_dout   <= mpeg_word;
        cdic_ack    <= 1'b0;
        mpeg_ack    <= 1'b0;
        cdic_intreq <= 1'b1;
        @(negedge clk30);
        compare_bit("in4", in4, 1'b0);
        @(negedge clk30);
        compare_bit("in4", in4, 1'b1);
        @(posedge clk30);
        iack4 <= 1'b1;
        as    <= 1'b1;
        uds   <= 1'b1;
        lds   <= 1'b1;
        @(negedge clk30);
        compare_bit("cdic_intack", cdic_intack, 1'b1);
        compare_bit("mpeg_intack", mpeg_intack, 1'b0);
        compare_word("data_in", data_in, cdic_word);
        compare_bit("bus_ack", bus_ack, 1'b1);
        @(posedge clk30);
        iack4       <= 1'b0;
        mpeg_intreq <= 1'b1;
        // CDIC keeps the line while it still asks
        repeat (2) @(posedge clk30);
        iack4 <= 1'b1;
        @(negedge clk30);
        compare_bit("in4", in4, 1'b1);
        compare_bit("cdic_intack", cdic_intack, 1'b1);
        compare_bit("mpeg_intack", mpeg_intack, 1'b0);
        @(posedge clk30);
        iack4       <= 1'b0;
        cdic_intreq <= 1'b0;
        @(negedge clk30);
        compare_bit("in4", in4, 1'b0);
        wait_for_in4(4, "MPEG");
        @(posedge clk30);
        iack4 <= 1'b1;
        @(negedge clk30);
        compare_bit("mpeg_intack", mpeg_intack, 1'b1);
        compare_bit("cdic_intack", cdic_intack, 1'b0);
        compare_word("data_in", data_in, mpeg_word);
        compare_bit("bus_ack", bus_ack, 1'b1);
        @(posedge clk30);
        iack4       <= 1'b0;
        mpeg_intreq <= 1'b0;
        repeat (2) @(posedge clk30);
        cdic_intreq <= 1'b1;
        mpeg_intreq <= 1'b1;
        @(negedge clk30);
        compare_bit("in4", in4, 1'b0);
        @(posedge clk30);
        iack4 <= 1'b1;
        @(negedge clk30);
        compare_bit("in4", in4, 1'b1);
        compare_bit("mpeg_intack", mpeg_intack, 1'b1);
        compare_bit("cdic_intack", cdic_intack, 1'b0);
        @(posedge clk30);
        iack4       <= 1'b0;
        as          <= 1'b0;
        uds         <= 1'b0;
        lds         <= 1'b0;
        cdic_intreq <= 1'b0;
        mpeg_intreq <= 1'b0;
    endtask

    initial begin
        void'($urandom(11));
        reset                = 1'b1;
        slave_reset          = 1'b0;
        addr                 = '0;
        as                   = 1'b0;
        uds                  = 1'b0;
        lds                  = 1'b0;
        video_dout           = '0;
        cdic_dout            = '0;
        mpeg_dout            = '0;
        video_ack            = 1'b0;
        cdic_ack             = 1'b0;
        mpeg_ack             = 1'b0;
        nvram_dout           = '0;
        nvram_ack            = 1'b0;
        slave_porta          = '0;
        slave_dtack          = 1'b0;
        cdic_intreq          = 1'b0;
        mpeg_intreq          = 1'b0;
        iack4                = 1'b0;
        cd_img_mounted       = 1'b0;
        config_auto_play     = 1'b0;
        audio_cd_in_tray     = 1'b0;
        config_disable_vmpeg = 1'b0;
        mpeg_ram_enabled     = 1'b1;
        repeat (10) @(posedge clk30);
        reset <= 1'b0;
        build_decode_table();
        foreach (decode_table[i]) begin
            apply_decode_row(decode_table[i]);
        end
        run_boot_rom_test();
        run_slave_port_test();
        run_irq4_test();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== boot_rom.mem ====
// One 16-bit word per line in hex, first line is the word at ROM_BASE
5000
5001
5002
5003
5004
5005
5006
5007
5008
5009
500a
500b
500c
500d
500e
500f
5010
5011
5012
5013
5014
5015
5016
5017
5018
5019
501a
501b
501c
501d
501e
501f
5020
5021
5022
5023
5024
5025
5026
5027
5028
5029
502a
502b
502c
502d
502e
502f
5030
5031
5032
5033
5034

// ==== filelist.f ====
verilog/cdi_bus_pkg.sv
verilog/cpu_bus_if.sv
verilog/addr_decoder.sv
verilog/boot_rom.sv
verilog/slave_port.sv
verilog/irq4_arbiter.sv
verilog/bus_response_mux.sv
verilog/cdi_bus_glue.sv
dv/cdi_bus_glue_asserts.sv
dv/cdi_bus_glue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log_file=sim.log

if ! verilator --binary --timing --assert --top-module cdi_bus_glue_tb \
        -f filelist.f --Mdir obj_dir -o cdi_bus_glue_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cdi_bus_glue_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
    exit 0
else
    echo "Pass message not found in $log_file"
    exit 1
fi
